// File: ctrl_fsm.sv
// main control fsm of the pipeline
// boot, sleep, jump wait, pipeline flush, pc redirect and exception entry

`timescale 1ns/1ns
`default_nettype none

module ctrl_fsm import ctrl_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,

  // core enable and stage status
  input  wire logic       fetch_enable_i,
  input  wire logic       instr_valid_i,
  input  wire logic       id_ready_i,
  input  wire logic       ex_valid_i,
  input  wire logic       fetch_valid_i,

  // branch result and requests
  input  wire logic       branch_taken_ex_i,
  input  wire logic       exc_req_i,
  input  wire logic       ext_req_i,

  // decoder flags
  input  wire logic       eret_insn_i,
  input  wire logic       pipe_flush_i,
  input  wire jump_kind_e jump_in_dec_i,

  // from the hazard unit
  input  wire logic       jr_stall_i,

  output logic            instr_req_o,
  output logic            ctrl_busy_o,
  output logic            is_decoding_o,
  output logic            in_wait_jump_o,
  output logic            pc_set_o,
  output pc_sel_e         pc_mux_o,
  output exc_ctrl_t       exc_ctrl_o,
  output logic            halt_if_o,
  output logic            halt_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // a redirect for the instruction in ID was already issued
  logic jump_done_q;
  logic jump_done_d;

  // unconditional jump in decode
  logic is_jump;

  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb begin
    // defaults: busy, fetching, no redirect
    state_d       = state_q;
    jump_done_d   = jump_done_q;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = PC_BOOT;
    exc_ctrl_o    = '0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;

    case (state_q)
      // idle after reset until the core is enabled
      RESET: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load boot address into the fetch stage
      BOOT_SET: begin
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      // pipeline is empty, wait for enable or an interrupt
      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i) begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // wake-up by interrupt: nothing in ID yet, save the IF pc
        if (exc_req_i) begin
          pc_mux_o           = PC_EXCEPTION;
          pc_set_o           = 1'b1;
          exc_ctrl_o.ack     = 1'b1;
          exc_ctrl_o.save_if = 1'b1;
        end
      end

      DECODE: begin
        // only decode when no taken branch in EX kills the ID instruction
        if (instr_valid_i && !branch_taken_ex_i) begin
          is_decoding_o = 1'b1;

          if (is_jump) begin
            if (id_ready_i) begin
              // target is known, stop fetch and redirect next cycle
              if (!jr_stall_i && !jump_done_q) begin
                halt_if_o = 1'b1;
                state_d   = WAIT_JUMP;
              end
            end else begin
              // back-pressure holds the jump in ID
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
            end
          end else if (exc_req_i && !eret_insn_i) begin
            // synchronous exception, keep the instruction out of EX
            pc_mux_o           = PC_EXCEPTION;
            pc_set_o           = 1'b1;
            exc_ctrl_o.ack     = 1'b1;
            exc_ctrl_o.save_id = 1'b1;
            halt_id_o          = 1'b1;
          end

          // eret wins over an exception request
          if (eret_insn_i) begin
            pc_mux_o              = PC_ERET;
            exc_ctrl_o.restore_id = 1'b1;
            if (!jump_done_q) begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end

          // wfi, or eret back to sleep: drain EX and WB first
          if (pipe_flush_i || (eret_insn_i && !fetch_enable_i)) begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // external interrupt with an empty ID stage
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i) begin
          pc_mux_o           = PC_EXCEPTION;
          pc_set_o           = 1'b1;
          exc_ctrl_o.ack     = 1'b1;
          exc_ctrl_o.save_if = 1'b1;
          halt_id_o          = 1'b1;
        end

        // taken branch in EX overrides everything decoded in ID
        if (branch_taken_ex_i) begin
          pc_mux_o = PC_BRANCH;
          pc_set_o = 1'b1;
          // interrupt is taken with the branch target as return address
          if (ext_req_i) begin
            pc_mux_o                    = PC_EXCEPTION;
            exc_ctrl_o.ack              = 1'b1;
            exc_ctrl_o.save_takenbranch = 1'b1;
            halt_id_o                   = 1'b1;
          end
        end
      end

      // jump left ID, keep redirecting until fetch delivers the target
      WAIT_JUMP: begin
        pc_mux_o    = PC_JUMP;
        pc_set_o    = 1'b1;
        jump_done_d = 1'b1;
        if (fetch_valid_i) begin
          state_d = DECODE;
        end
      end

      // NOP into EX, wait for EX to finish
      FLUSH_EX: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i) begin
          state_d = FLUSH_WB;
        end
      end

      // NOP into WB, then resume or sleep
      FLUSH_WB: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i) begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end else begin
          state_d = SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  assign in_wait_jump_o = (state_q == WAIT_JUMP);

  //////////////////////////////
  // state registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // ID accepting a new instruction ends the redirect window
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

  //////////////////////////////
  // assertions
  //////////////////////////////

  // no branch prediction, so EX never sees two taken branches in a row
  a_branch_not_b2b: assert property (
    @(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i
  ) else $error("taken branches on consecutive cycles");

endmodule

`default_nettype wire

// File: ctrl_pkg.sv
// controller types
// fsm states, pc source selector, jump classes, exception control bundle

`default_nettype none

`include "riscv_ctrl_cfg.svh"

package ctrl_pkg;

  //////////////////////////////
  // fsm
  //////////////////////////////

  // main controller states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    WAIT_JUMP,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

  //////////////////////////////
  // fetch redirect
  //////////////////////////////

  // pc source seen by the fetch stage
  // code 1 is left free
  typedef enum logic [`RISCV_CTRL_PC_SEL_W-1:0] {
    PC_BOOT      = 0,
    PC_JUMP      = 2,
    PC_BRANCH    = 3,
    PC_EXCEPTION = 4,
    PC_ERET      = 5
  } pc_sel_e;

  // jump class from the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'd0,
    BRANCH_JAL  = 2'd1,
    BRANCH_JALR = 2'd2,
    BRANCH_COND = 2'd3
  } jump_kind_e;

  // strobes towards the exception controller
  typedef struct packed {
    // request accepted
    logic ack;
    // save pc of IF, ID or the branch target
    logic save_if;
    logic save_id;
    logic save_takenbranch;
    // eret restores the saved pc
    logic restore_id;
  } exc_ctrl_t;

endpackage

`default_nettype wire

// File: fwd_pkg.sv
// forwarding types
// operand source selector, register write ports and match flags

`default_nettype none

`include "riscv_ctrl_cfg.svh"

package fwd_pkg;

  // operand source for the ID stage mux
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'd0,
    SEL_FW_EX   = 2'd1,
    SEL_FW_WB   = 2'd2
  } fwd_sel_e;

  // one register write port
  typedef struct packed {
    logic                          we;
    logic [`RISCV_CTRL_REG_AW-1:0] addr;
  } wport_t;

  // all write ports visible to the ID stage
  typedef struct packed {
    // load or EX result
    wport_t ex;
    // alu forward path
    wport_t alu;
    // writeback
    wport_t wb;
  } wports_t;

  // one hit flag per write port and operand
  typedef struct packed {
    logic ex_a;
    logic ex_b;
    logic alu_a;
    logic alu_b;
    logic wb_a;
    logic wb_b;
  } src_match_t;

endpackage

`default_nettype wire

// File: fwd_unit.sv
// operand forwarding for operands A and B
// compares read addresses with write ports and picks the mux source

`timescale 1ns/1ns
`default_nettype none

`include "riscv_ctrl_cfg.svh"

module fwd_unit import fwd_pkg::*; (
  // ID stage read addresses
  input  wire logic [`RISCV_CTRL_REG_AW-1:0] rs_a_i,
  input  wire logic [`RISCV_CTRL_REG_AW-1:0] rs_b_i,
  input  wire logic                          rega_used_i,
  input  wire logic                          regb_used_i,

  // write ports of EX, alu forward and WB
  input  wire wports_t                       wports_i,

  output src_match_t                         match_o,
  output fwd_sel_e                           fwd_a_sel_o,
  output fwd_sel_e                           fwd_b_sel_o
);

  localparam int unsigned REG_NUM = `RISCV_CTRL_REG_NUM;

  // address width must cover the register file exactly
  if (REG_NUM != (1 << `RISCV_CTRL_REG_AW)) begin : g_cfg_check
    $error("register count does not fit the address width");
  end

  // hit on a used, nonzero source by an enabled port
  // x0 is hardwired, never forwarded
  function automatic logic port_hit(
    input wport_t                        port,
    input logic [`RISCV_CTRL_REG_AW-1:0] rs,
    input logic                          used
  );
    return used && port.we && (rs != '0) && (port.addr == rs);
  endfunction

  //////////////////////////////
  // address compare
  //////////////////////////////

  assign match_o.ex_a  = port_hit(wports_i.ex, rs_a_i, rega_used_i);
  assign match_o.ex_b  = port_hit(wports_i.ex, rs_b_i, regb_used_i);
  assign match_o.alu_a = port_hit(wports_i.alu, rs_a_i, rega_used_i);
  assign match_o.alu_b = port_hit(wports_i.alu, rs_b_i, regb_used_i);
  assign match_o.wb_a  = port_hit(wports_i.wb, rs_a_i, rega_used_i);
  assign match_o.wb_b  = port_hit(wports_i.wb, rs_b_i, regb_used_i);

  //////////////////////////////
  // source select
  //////////////////////////////

  // youngest result first: alu forward, then writeback
  assign fwd_a_sel_o = match_o.alu_a ? SEL_FW_EX :
                       match_o.wb_a  ? SEL_FW_WB : SEL_REGFILE;
  assign fwd_b_sel_o = match_o.alu_b ? SEL_FW_EX :
                       match_o.wb_b  ? SEL_FW_WB : SEL_REGFILE;

endmodule

`default_nettype wire

// File: hazard_unit.sv
// stall detection for the ID stage
// load-use and jump-register stalls, write enable deassert

`timescale 1ns/1ns
`default_nettype none

module hazard_unit import ctrl_pkg::*, fwd_pkg::*; (
  input  wire src_match_t match_i,
  input  wire logic       data_req_ex_i,
  input  wire logic       illegal_insn_i,

  // fsm status
  input  wire logic       is_decoding_i,
  input  wire logic       in_wait_jump_i,

  input  wire jump_kind_e jump_in_dec_i,

  output logic            load_stall_o,
  output logic            jr_stall_o,
  output logic            deassert_we_o
);

  logic no_decode;

  // load in EX writes a register that ID reads
  // data only arrives after the memory access
  assign load_stall_o = data_req_ex_i & (match_i.ex_a | match_i.ex_b);

  // jalr target depends on a result still in flight
  // pc path has no forwarding, so wait for any pending writer
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) &
                      (match_i.ex_a | match_i.alu_a | match_i.wb_a);

  // nothing valid decoded, except a jump leaving through WAIT_JUMP
  assign no_decode = ~is_decoding_i & ~in_wait_jump_i;

  // block register write of the ID instruction
  assign deassert_we_o = no_decode | illegal_insn_i | load_stall_o | jr_stall_o;

endmodule

`default_nettype wire

// File: riscv_ctrl.f
+incdir+.
ctrl_pkg.sv
fwd_pkg.sv
ctrl_fsm.sv
fwd_unit.sv
hazard_unit.sv
riscv_ctrl.sv
tb_clk_gen.sv
tb_riscv_ctrl.sv

// File: riscv_ctrl.sv
// controller top level
// fsm, operand forwarding and hazard detection

`timescale 1ns/1ns
`default_nettype none

`include "riscv_ctrl_cfg.svh"

module riscv_ctrl import ctrl_pkg::*, fwd_pkg::*; (
  input  wire logic                          clk,
  input  wire logic                          rst_n,

  // stage status
  input  wire logic                          fetch_enable_i,
  input  wire logic                          instr_valid_i,
  input  wire logic                          id_ready_i,
  input  wire logic                          ex_valid_i,
  input  wire logic                          fetch_valid_i,

  // decoder flags
  input  wire logic                          illegal_insn_i,
  input  wire logic                          eret_insn_i,
  input  wire logic                          pipe_flush_i,
  input  wire jump_kind_e                    jump_in_dec_i,
  input  wire logic                          rega_used_i,
  input  wire logic                          regb_used_i,

  // register addresses and write ports
  input  wire logic [`RISCV_CTRL_REG_AW-1:0] rs_a_i,
  input  wire logic [`RISCV_CTRL_REG_AW-1:0] rs_b_i,
  input  wire wports_t                       wports_i,
  input  wire logic                          data_req_ex_i,

  // requests and branch result
  input  wire logic                          exc_req_i,
  input  wire logic                          ext_req_i,
  input  wire logic                          branch_taken_ex_i,

  // fetch control
  output logic                               instr_req_o,
  output logic                               ctrl_busy_o,
  output logic                               pc_set_o,
  output pc_sel_e                            pc_mux_o,
  output exc_ctrl_t                          exc_ctrl_o,
  output logic                               halt_if_o,
  output logic                               halt_id_o,

  // ID stage control
  output fwd_sel_e                           fwd_a_sel_o,
  output fwd_sel_e                           fwd_b_sel_o,
  output logic                               load_stall_o,
  output logic                               deassert_we_o
);

  src_match_t match;
  logic       jr_stall;
  logic       is_decoding;
  logic       in_wait_jump;

  ctrl_fsm u_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .fetch_valid_i     (fetch_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .exc_req_i         (exc_req_i),
    .ext_req_i         (ext_req_i),
    .eret_insn_i       (eret_insn_i),
    .pipe_flush_i      (pipe_flush_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .jr_stall_i        (jr_stall),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding),
    .in_wait_jump_o    (in_wait_jump),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .exc_ctrl_o        (exc_ctrl_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  fwd_unit u_fwd (
    .rs_a_i      (rs_a_i),
    .rs_b_i      (rs_b_i),
    .rega_used_i (rega_used_i),
    .regb_used_i (regb_used_i),
    .wports_i    (wports_i),
    .match_o     (match),
    .fwd_a_sel_o (fwd_a_sel_o),
    .fwd_b_sel_o (fwd_b_sel_o)
  );

  hazard_unit u_hazard (
    .match_i        (match),
    .data_req_ex_i  (data_req_ex_i),
    .illegal_insn_i (illegal_insn_i),
    .is_decoding_i  (is_decoding),
    .in_wait_jump_i (in_wait_jump),
    .jump_in_dec_i  (jump_in_dec_i),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall),
    .deassert_we_o  (deassert_we_o)
  );

endmodule

`default_nettype wire

// File: riscv_ctrl_cfg.svh
// controller configuration macros
// register file addressing and pc selector width

`ifndef RISCV_CTRL_CFG_SVH
`define RISCV_CTRL_CFG_SVH

// register file address width
`define RISCV_CTRL_REG_AW 5

// number of architectural registers, x0 included
`define RISCV_CTRL_REG_NUM 32

// pc source selector width towards the fetch stage
`define RISCV_CTRL_PC_SEL_W 3

`endif

// File: tb_clk_gen.sv
// testbench clock and reset source
// 10 ns clock, active low reset held for two cycles

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

  // release on a falling edge, away from the active edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_riscv_ctrl.sv
// testbench for the pipeline controller
// directed tests: boot, forwarding, stalls, jump, exceptions, flush and sleep
// inputs change on the falling edge, outputs are checked 1 ns later

`timescale 1ns/1ns
`default_nettype none

`include "riscv_ctrl_cfg.svh"

module tb_riscv_ctrl import ctrl_pkg::*, fwd_pkg::*; ();

  //////////////////////////////
  // run length
  //////////////////////////////

  localparam int FWD_SETS        = 200;
  localparam int CYCLES_BOOT     = 10;
  localparam int CYCLES_FWD      = FWD_SETS + 2;
  localparam int CYCLES_STALL    = 8;
  localparam int CYCLES_JUMP     = 16;
  localparam int CYCLES_EXC      = 10;
  localparam int CYCLES_FLUSH    = 16;
  // reset plus all tests, with a factor 2 margin
  localparam int WATCHDOG_CYCLES = 2 * (2 + CYCLES_BOOT + CYCLES_FWD + CYCLES_STALL +
                                        CYCLES_JUMP + CYCLES_EXC + CYCLES_FLUSH);

  logic clk;
  logic rst_n;

  // DUT inputs
  logic                          fetch_enable;
  logic                          instr_valid;
  logic                          id_ready;
  logic                          ex_valid;
  logic                          fetch_valid;
  logic                          illegal_insn;
  logic                          eret_insn;
  logic                          pipe_flush;
  jump_kind_e                    jump_in_dec;
  logic                          rega_used;
  logic                          regb_used;
  logic [`RISCV_CTRL_REG_AW-1:0] rs_a;
  logic [`RISCV_CTRL_REG_AW-1:0] rs_b;
  wports_t                       wports;
  logic                          data_req_ex;
  logic                          exc_req;
  logic                          ext_req;
  logic                          branch_taken_ex;

  // DUT outputs
  logic      instr_req;
  logic      ctrl_busy;
  logic      pc_set;
  pc_sel_e   pc_mux;
  exc_ctrl_t exc_ctrl;
  logic      halt_if;
  logic      halt_id;
  fwd_sel_e  fwd_a_sel;
  fwd_sel_e  fwd_b_sel;
  logic      load_stall;
  logic      deassert_we;

  int unsigned errors;
  int unsigned checks;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  riscv_ctrl u_riscv_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable),
    .instr_valid_i     (instr_valid),
    .id_ready_i        (id_ready),
    .ex_valid_i        (ex_valid),
    .fetch_valid_i     (fetch_valid),
    .illegal_insn_i    (illegal_insn),
    .eret_insn_i       (eret_insn),
    .pipe_flush_i      (pipe_flush),
    .jump_in_dec_i     (jump_in_dec),
    .rega_used_i       (rega_used),
    .regb_used_i       (regb_used),
    .rs_a_i            (rs_a),
    .rs_b_i            (rs_b),
    .wports_i          (wports),
    .data_req_ex_i     (data_req_ex),
    .exc_req_i         (exc_req),
    .ext_req_i         (ext_req),
    .branch_taken_ex_i (branch_taken_ex),
    .instr_req_o       (instr_req),
    .ctrl_busy_o       (ctrl_busy),
    .pc_set_o          (pc_set),
    .pc_mux_o          (pc_mux),
    .exc_ctrl_o        (exc_ctrl),
    .halt_if_o         (halt_if),
    .halt_id_o         (halt_id),
    .fwd_a_sel_o       (fwd_a_sel),
    .fwd_b_sel_o       (fwd_b_sel),
    .load_stall_o      (load_stall),
    .deassert_we_o     (deassert_we)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check(input string test, input string what, input logic [31:0] exp,
                       input logic [31:0] act);
    checks++;
    a_value: assert (act === exp)
      else begin
        errors++;
        $display("[FAIL] %s %s: expected %0h, actual %0h", test, what, exp, act);
      end
  endtask

  task automatic expect_halts(input string test, input logic exp_if, input logic exp_id);
    check(test, "halt_if", exp_if, halt_if);
    check(test, "halt_id", exp_id, halt_id);
  endtask

  // everything idle except fetch_enable and id_ready
  task automatic clear_inputs();
    instr_valid     = 1'b0;
    ex_valid        = 1'b0;
    fetch_valid     = 1'b0;
    illegal_insn    = 1'b0;
    eret_insn       = 1'b0;
    pipe_flush      = 1'b0;
    jump_in_dec     = BRANCH_NONE;
    rega_used       = 1'b0;
    regb_used       = 1'b0;
    rs_a            = '0;
    rs_b            = '0;
    wports          = '0;
    data_req_ex     = 1'b0;
    exc_req         = 1'b0;
    ext_req         = 1'b0;
    branch_taken_ex = 1'b0;
  endtask

  function automatic exc_ctrl_t exc_expect(input logic ack, input logic sif, input logic sid,
                                           input logic stb, input logic rid);
    exc_ctrl_t e;
    e                  = '0;
    e.ack              = ack;
    e.save_if          = sif;
    e.save_id          = sid;
    e.save_takenbranch = stb;
    e.restore_id       = rid;
    return e;
  endfunction

  // a used, nonzero operand written by an enabled port
  function automatic logic port_writes(input wport_t p, input logic [`RISCV_CTRL_REG_AW-1:0] rs,
                                       input logic used);
    return used && (rs != 0) && p.we && (p.addr == rs);
  endfunction

  // alu forward over writeback over register file
  function automatic fwd_sel_e expected_sel(input logic [`RISCV_CTRL_REG_AW-1:0] rs,
                                            input logic used, input wports_t w);
    if (port_writes(w.alu, rs, used)) begin
      return SEL_FW_EX;
    end
    if (port_writes(w.wb, rs, used)) begin
      return SEL_FW_WB;
    end
    return SEL_REGFILE;
  endfunction

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic reset_and_boot();
    string t;
    t = "reset_boot";
    @(negedge clk);
    #1;
    check(t, "ctrl_busy", 0, ctrl_busy);
    check(t, "instr_req", 0, instr_req);
    check(t, "pc_set", 0, pc_set);
    check(t, "exc_ctrl", 0, exc_ctrl);
    expect_halts(t, 0, 0);
    @(negedge clk);
    fetch_enable = 1'b1;
    #1;
    check(t, "pc_set in reset", 0, pc_set);
    // boot address load, one cycle only
    @(negedge clk);
    #1;
    check(t, "pc_set boot", 1, pc_set);
    check(t, "pc_mux boot", PC_BOOT, pc_mux);
    check(t, "ctrl_busy boot", 1, ctrl_busy);
    @(negedge clk);
    #1;
    check(t, "pc_set after boot", 0, pc_set);
    check(t, "deassert_we first fetch", 1, deassert_we);
    @(negedge clk);
    id_ready = 1'b1;
    #1;
    check(t, "pc_set first fetch", 0, pc_set);
    // now in decode
    @(negedge clk);
    instr_valid = 1'b1;
    #1;
    check(t, "deassert_we valid", 0, deassert_we);
    @(negedge clk);
    instr_valid = 1'b0;
    #1;
    check(t, "deassert_we empty", 1, deassert_we);
  endtask

  task automatic forwarding_select();
    string       t;
    int unsigned pool;
    logic        exp_load;
    t = "forwarding";
    for (int i = 0; i < FWD_SETS; i++) begin
      // small address pool on odd sets so hits are frequent
      pool = (i % 2 == 0) ? 32 : 4;
      @(negedge clk);
      clear_inputs();
      instr_valid       = 1'b1;
      rs_a              = $urandom % pool;
      rs_b              = $urandom % pool;
      rega_used         = $urandom % 2;
      regb_used         = $urandom % 2;
      wports.ex.we      = $urandom % 2;
      wports.ex.addr    = $urandom % pool;
      wports.alu.we     = $urandom % 2;
      wports.alu.addr   = $urandom % pool;
      wports.wb.we      = $urandom % 2;
      wports.wb.addr    = $urandom % pool;
      data_req_ex       = $urandom % 2;
      exp_load = data_req_ex && (port_writes(wports.ex, rs_a, rega_used) ||
                                 port_writes(wports.ex, rs_b, regb_used));
      #1;
      check(t, "fwd_a_sel", expected_sel(rs_a, rega_used, wports), fwd_a_sel);
      check(t, "fwd_b_sel", expected_sel(rs_b, regb_used, wports), fwd_b_sel);
      check(t, "load_stall", exp_load, load_stall);
      check(t, "deassert_we", exp_load, deassert_we);
    end
  endtask

  task automatic stall_detect();
    string t;
    t = "stalls";
    // load in EX writes operand B
    @(negedge clk);
    clear_inputs();
    instr_valid    = 1'b1;
    data_req_ex    = 1'b1;
    regb_used      = 1'b1;
    rs_b           = 5'd9;
    wports.ex.we   = 1'b1;
    wports.ex.addr = 5'd9;
    #1;
    check(t, "load_stall", 1, load_stall);
    check(t, "deassert_we load", 1, deassert_we);
    check(t, "fwd_b_sel load", SEL_REGFILE, fwd_b_sel);
    // jalr waits on a pending writer of operand A, one port at a time
    for (int p = 0; p < 3; p++) begin
      @(negedge clk);
      clear_inputs();
      instr_valid = 1'b1;
      jump_in_dec = BRANCH_JALR;
      rega_used   = 1'b1;
      rs_a        = 5'd12;
      case (p)
        0:       wports.ex  = '{we: 1'b1, addr: 5'd12};
        1:       wports.alu = '{we: 1'b1, addr: 5'd12};
        default: wports.wb  = '{we: 1'b1, addr: 5'd12};
      endcase
      #1;
      check(t, "deassert_we jalr", 1, deassert_we);
      check(t, "load_stall jalr", 0, load_stall);
      check(t, "halt_if jalr", 0, halt_if);
      check(t, "pc_set jalr", 0, pc_set);
    end
    // jalr never left decode
    @(negedge clk);
    clear_inputs();
    instr_valid = 1'b1;
    #1;
    check(t, "pc_set after jalr", 0, pc_set);
    check(t, "deassert_we after jalr", 0, deassert_we);
    @(negedge clk);
    illegal_insn = 1'b1;
    #1;
    check(t, "deassert_we illegal", 1, deassert_we);
    check(t, "load_stall illegal", 0, load_stall);
    check(t, "pc_set illegal", 0, pc_set);
    expect_halts(t, 0, 0);
  endtask

  task automatic jump_redirect();
    string       t;
    int unsigned hold;
    t    = "jump";
    hold = 1 + $urandom % 4;
    // back-pressure keeps the jal in ID
    repeat (hold) begin
      @(negedge clk);
      clear_inputs();
      instr_valid = 1'b1;
      jump_in_dec = BRANCH_JAL;
      id_ready    = 1'b0;
      #1;
      expect_halts(t, 1, 1);
      check(t, "pc_set held", 0, pc_set);
    end
    @(negedge clk);
    id_ready = 1'b1;
    #1;
    expect_halts(t, 1, 0);
    check(t, "pc_set jal", 0, pc_set);
    // redirect repeats until fetch delivers the target
    hold = 1 + $urandom % 3;
    repeat (hold) begin
      @(negedge clk);
      clear_inputs();
      #1;
      check(t, "pc_set wait", 1, pc_set);
      check(t, "pc_mux wait", PC_JUMP, pc_mux);
      check(t, "deassert_we wait", 0, deassert_we);
    end
    @(negedge clk);
    fetch_valid = 1'b1;
    #1;
    check(t, "pc_set fetch_valid", 1, pc_set);
    check(t, "pc_mux fetch_valid", PC_JUMP, pc_mux);
    @(negedge clk);
    clear_inputs();
    instr_valid = 1'b1;
    #1;
    check(t, "pc_set resume", 0, pc_set);
    check(t, "deassert_we resume", 0, deassert_we);
    expect_halts(t, 0, 0);
  endtask

  task automatic exception_entry();
    string t;
    t = "exceptions";
    @(negedge clk);
    clear_inputs();
    instr_valid = 1'b1;
    exc_req     = 1'b1;
    #1;
    check(t, "pc_set exc", 1, pc_set);
    check(t, "pc_mux exc", PC_EXCEPTION, pc_mux);
    check(t, "exc_ctrl exc", exc_expect(1, 0, 1, 0, 0), exc_ctrl);
    expect_halts(t, 0, 1);
    // external request, ID empty
    @(negedge clk);
    clear_inputs();
    ext_req = 1'b1;
    #1;
    check(t, "pc_mux ext", PC_EXCEPTION, pc_mux);
    check(t, "exc_ctrl ext", exc_expect(1, 1, 0, 0, 0), exc_ctrl);
    @(negedge clk);
    clear_inputs();
    instr_valid     = 1'b1;
    branch_taken_ex = 1'b1;
    #1;
    check(t, "pc_mux branch", PC_BRANCH, pc_mux);
    check(t, "exc_ctrl branch", 0, exc_ctrl);
    // gap between taken branches
    @(negedge clk);
    clear_inputs();
    instr_valid = 1'b1;
    #1;
    check(t, "pc_set idle", 0, pc_set);
    @(negedge clk);
    branch_taken_ex = 1'b1;
    ext_req         = 1'b1;
    #1;
    check(t, "pc_mux branch ext", PC_EXCEPTION, pc_mux);
    check(t, "exc_ctrl branch ext", exc_expect(1, 0, 0, 1, 0), exc_ctrl);
    check(t, "halt_id branch ext", 1, halt_id);
    // eret over a pending exception
    @(negedge clk);
    clear_inputs();
    instr_valid = 1'b1;
    eret_insn   = 1'b1;
    exc_req     = 1'b1;
    #1;
    check(t, "pc_set eret", 1, pc_set);
    check(t, "pc_mux eret", PC_ERET, pc_mux);
    check(t, "exc_ctrl eret", exc_expect(0, 0, 0, 0, 1), exc_ctrl);
    @(negedge clk);
    clear_inputs();
    instr_valid = 1'b1;
    #1;
    check(t, "pc_set after eret", 0, pc_set);
    check(t, "exc_ctrl after eret", 0, exc_ctrl);
  endtask

  task automatic flush_and_sleep();
    string       t;
    int unsigned hold;
    t = "flush_sleep";
    @(negedge clk);
    clear_inputs();
    instr_valid = 1'b1;
    pipe_flush  = 1'b1;
    #1;
    expect_halts(t, 1, 1);
    // EX drains for a while
    hold = 1 + $urandom % 4;
    repeat (hold) begin
      @(negedge clk);
      clear_inputs();
      #1;
      expect_halts(t, 1, 1);
      check(t, "pc_set flush", 0, pc_set);
    end
    @(negedge clk);
    ex_valid     = 1'b1;
    fetch_enable = 1'b0;
    #1;
    expect_halts(t, 1, 1);
    @(negedge clk);
    clear_inputs();
    #1;
    expect_halts(t, 1, 1);
    check(t, "ctrl_busy flush_wb", 1, ctrl_busy);
    repeat (2) begin
      @(negedge clk);
      #1;
      check(t, "ctrl_busy sleep", 0, ctrl_busy);
      check(t, "instr_req sleep", 0, instr_req);
      check(t, "pc_set sleep", 0, pc_set);
      expect_halts(t, 1, 1);
    end
    // interrupt wake-up
    @(negedge clk);
    exc_req = 1'b1;
    #1;
    check(t, "ctrl_busy wake", 0, ctrl_busy);
    @(negedge clk);
    exc_req      = 1'b0;
    fetch_enable = 1'b1;
    id_ready     = 1'b1;
    #1;
    check(t, "ctrl_busy first fetch", 1, ctrl_busy);
    check(t, "instr_req first fetch", 1, instr_req);
    check(t, "pc_set first fetch", 0, pc_set);
    expect_halts(t, 0, 0);
    @(negedge clk);
    instr_valid = 1'b1;
    #1;
    check(t, "deassert_we decode", 0, deassert_we);
    check(t, "ctrl_busy decode", 1, ctrl_busy);
  endtask

  //////////////////////////////
  // run
  //////////////////////////////

  initial begin
    errors       = 0;
    checks       = 0;
    fetch_enable = 1'b0;
    id_ready     = 1'b0;
    clear_inputs();
    void'($urandom(32'hfc44));
    @(posedge rst_n);
    reset_and_boot();
    forwarding_select();
    stall_detect();
    jump_redirect();
    exception_entry();
    flush_and_sleep();
    @(negedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
